/* common/caster_pkg.sv */
`default_nettype none

package caster_pkg;

    // Datapath sizes
    localparam int PIX_PER_CLK = 4;
    localparam int VIN_PIX_W = 8;
    localparam int GRAY_W = 4;
    localparam int STATE_W = 16;
    localparam int FCNT_W = 6;
    localparam int CNT_W = 11;
    localparam int DRIVE_W = 2;

    // Waveform table, 6-bit sequence + 4-bit target + 4-bit source
    localparam int LUT_ADDR_W = 14;
    localparam int LUT_WADDR_W = 12;
    localparam int LUT_DATA_W = 8;

    // Clocks spent waiting after vsync, and fetch lead ahead of the active column
    localparam int VS_DELAY = 8;
    localparam int PIPELINE_DELAY = 4;

    // Value of the mode bit for pixels that follow the shared counter
    localparam logic MODE_AUTO = 1'b1;

    typedef struct packed {
        logic mode;
        logic spare;
        logic [GRAY_W-1:0] src;
        logic [FCNT_W-1:0] fcnt;
        logic [GRAY_W-1:0] tgt;
    } manual_state_t;

    typedef struct packed {
        logic mode;
        logic [5:0] spare;
        logic auto_frame;
        logic [GRAY_W-1:0] src;
        logic [GRAY_W-1:0] tgt;
    } auto_state_t;

    typedef union packed {
        manual_state_t manual_view;
        auto_state_t auto_view;
    } pixel_state_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_WAITING,
        SCAN_RUNNING
    } scan_state_t;

endpackage

`default_nettype wire

/* common/scan_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface scan_if;
    import caster_pkg::*;

    // Stage-1 strobe, same as the ready of both input FIFOs
    logic fetch;
    // Shared frame counter for auto-mode pixels
    logic [FCNT_W-1:0] auto_fcnt;
    logic frame_start;
    // Some auto-mode pixel changed target this cycle
    logic auto_diff;

    modport ctrl (
        output fetch,
        output auto_fcnt,
        output frame_start,
        input  auto_diff
    );

    modport pipe (
        input  fetch,
        input  auto_fcnt,
        input  frame_start,
        output auto_diff
    );

endinterface

`default_nettype wire

/* source/scan_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module scan_controller #(
    parameter int V_FP = 3,
    parameter int V_SYNC = 1,
    parameter int V_BP = 2,
    parameter int V_ACT = 120,
    parameter int H_FP = 2,
    parameter int H_SYNC = 1,
    parameter int H_BP = 2,
    parameter int H_ACT = 40
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          sys_ready,
    input  wire                          vin_vsync,
    input  wire [caster_pkg::FCNT_W-1:0] lut_frames,
    output logic                         b_trigger,
    output logic                         epd_gdoe,
    output logic                         epd_gdclk,
    output logic                         epd_gdsp,
    output logic                         epd_sdclk,
    output logic                         epd_sdle,
    output logic                         epd_sdoe,
    output logic                         epd_sdce0,
    output logic                         fetch_out,
    scan_if.ctrl                         scan
);
    import caster_pkg::*;

    localparam logic [CNT_W-1:0] V_SYNC_START = CNT_W'(V_FP);
    localparam logic [CNT_W-1:0] V_BP_START = CNT_W'(V_FP + V_SYNC);
    localparam logic [CNT_W-1:0] V_ACT_START = CNT_W'(V_FP + V_SYNC + V_BP);
    localparam logic [CNT_W-1:0] V_LAST = CNT_W'(V_FP + V_SYNC + V_BP + V_ACT - 1);
    localparam logic [CNT_W-1:0] H_SYNC_START = CNT_W'(H_FP);
    localparam logic [CNT_W-1:0] H_BP_START = CNT_W'(H_FP + H_SYNC);
    localparam logic [CNT_W-1:0] H_ACT_START = CNT_W'(H_FP + H_SYNC + H_BP);
    localparam logic [CNT_W-1:0] H_LAST = CNT_W'(H_FP + H_SYNC + H_BP + H_ACT - 1);
    localparam logic [CNT_W-1:0] FETCH_START = CNT_W'(H_FP + H_SYNC + H_BP - PIPELINE_DELAY);
    localparam logic [CNT_W-1:0] FETCH_END = CNT_W'(H_FP + H_SYNC + H_BP + H_ACT - PIPELINE_DELAY);
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(VS_DELAY);

    scan_state_t state;
    logic [CNT_W-1:0] h_cnt;
    logic [CNT_W-1:0] v_cnt;
    logic scanning;
    logic in_vsync;
    logic in_vbp;
    logic in_vact;
    logic in_hfp;
    logic in_hsync;
    logic in_hbp;
    logic in_hact;
    logic diff_seen;

    assign scan.frame_start = (state == SCAN_WAITING) && (h_cnt == WAIT_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && vin_vsync) begin
                        state <= SCAN_WAITING;
                    end
                end
                SCAN_WAITING: begin
                    if (scan.frame_start) begin
                        state <= SCAN_RUNNING;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                SCAN_RUNNING: begin
                    if (h_cnt == H_LAST) begin
                        if (v_cnt == V_LAST) begin
                            state <= SCAN_IDLE;
                        end else begin
                            h_cnt <= '0;
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // Auto counter steps once per frame, reloading only after a change was seen
    always_ff @(posedge clk) begin
        if (rst) begin
            scan.auto_fcnt <= '0;
            diff_seen <= 1'b0;
        end else if (scan.frame_start) begin
            if (scan.auto_fcnt == '0) begin
                if (diff_seen) begin
                    scan.auto_fcnt <= lut_frames;
                end
            end else begin
                scan.auto_fcnt <= scan.auto_fcnt - 1'b1;
            end
            diff_seen <= 1'b0;
        end else if (scan.auto_diff) begin
            diff_seen <= 1'b1;
        end
    end

    // Region decode, regions are live in waiting as well as running
    assign scanning = (state != SCAN_IDLE);
    assign in_vsync = scanning && (v_cnt >= V_SYNC_START) && (v_cnt < V_BP_START);
    assign in_vbp = scanning && (v_cnt >= V_BP_START) && (v_cnt < V_ACT_START);
    assign in_vact = scanning && (v_cnt >= V_ACT_START);
    assign in_hfp = scanning && (h_cnt < H_SYNC_START);
    assign in_hsync = scanning && (h_cnt >= H_SYNC_START) && (h_cnt < H_BP_START);
    assign in_hbp = scanning && (h_cnt >= H_BP_START) && (h_cnt < H_ACT_START);
    assign in_hact = scanning && (h_cnt >= H_ACT_START);

    // Fetch leads the active column by the pipeline depth
    assign scan.fetch = in_vact && (h_cnt >= FETCH_START) && (h_cnt < FETCH_END);
    assign fetch_out = scan.fetch;

    // Gate clock lags the horizontal regions by one clock
    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
        end else begin
            epd_gdclk <= in_hsync || in_hbp || in_hact;
        end
    end

    assign epd_gdoe = in_vsync || in_vbp || in_vact;
    assign epd_sdoe = epd_gdoe;
    assign epd_gdsp = !in_vsync;
    assign epd_sdle = in_hsync;
    assign epd_sdce0 = !(in_vact && in_hact);
    assign epd_sdclk = (in_hfp || in_hsync || in_hact) ? ~clk : 1'b0;
    assign b_trigger = (state == SCAN_WAITING);

endmodule

`default_nettype wire

/* pixel_pipe/waveform_lut.sv */
`timescale 1ns/1ns
`default_nettype none

module waveform_lut (
    input  wire                                                     clk,
    input  wire                                                     we,
    input  wire [caster_pkg::LUT_WADDR_W-1:0]                       waddr,
    input  wire [caster_pkg::LUT_DATA_W-1:0]                        wdata,
    input  wire [caster_pkg::PIX_PER_CLK-1:0][caster_pkg::LUT_ADDR_W-1:0] raddr,
    output logic [caster_pkg::PIX_PER_CLK-1:0][caster_pkg::DRIVE_W-1:0]   rdata
);
    import caster_pkg::*;

    localparam int DEPTH = 2 ** LUT_WADDR_W;
    localparam int SEL_W = LUT_ADDR_W - LUT_WADDR_W;

    // Each byte packs four consecutive 2-bit entries, lowest entry in bits 1:0
    logic [LUT_DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < PIX_PER_CLK; p++) begin
            rdata[p] <= mem[raddr[p][LUT_ADDR_W-1:SEL_W]][raddr[p][SEL_W-1:0]*DRIVE_W +: DRIVE_W];
        end
    end

endmodule

`default_nettype wire

/* pixel_pipe/pixel_update.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_update (
    input  wire caster_pkg::pixel_state_t  state_in,
    input  wire [caster_pkg::GRAY_W-1:0]   new_gray,
    input  wire [caster_pkg::DRIVE_W-1:0]  lut_code,
    input  wire [caster_pkg::FCNT_W-1:0]   lut_frames,
    input  wire [caster_pkg::FCNT_W-1:0]   auto_fcnt,
    output logic [caster_pkg::DRIVE_W-1:0] drive,
    output caster_pkg::pixel_state_t       state_out,
    output logic                           differs
);
    import caster_pkg::*;

    always_comb begin
        state_out = state_in;
        drive = '0;
        differs = 1'b0;
        if (state_in.manual_view.mode != MODE_AUTO) begin
            // Manual mode keeps its own frame count in the word
            if (state_in.manual_view.fcnt != '0) begin
                drive = lut_code;
                state_out.manual_view.fcnt = state_in.manual_view.fcnt - 1'b1;
                // Target becomes the new source after the last frame
                if (state_in.manual_view.fcnt == FCNT_W'(1)) begin
                    state_out.manual_view.src = state_in.manual_view.tgt;
                end
            end else if (new_gray != state_in.manual_view.src) begin
                state_out.manual_view.tgt = new_gray;
                state_out.manual_view.fcnt = lut_frames;
            end
        end else begin
            // Auto mode follows the shared counter
            if (auto_fcnt != '0) begin
                drive = lut_code;
            end
            if (auto_fcnt == FCNT_W'(1)) begin
                state_out.auto_view.src = state_in.auto_view.tgt;
            end
            if (auto_fcnt == '0) begin
                state_out.auto_view.tgt = new_gray;
                differs = (new_gray != state_in.auto_view.tgt);
            end
        end
    end

endmodule

`default_nettype wire

/* pixel_pipe/pixel_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_pipe (
    input  wire                                                     clk,
    input  wire                                                     rst,
    input  wire [caster_pkg::PIX_PER_CLK*caster_pkg::VIN_PIX_W-1:0] vin_pixel,
    input  wire [caster_pkg::PIX_PER_CLK*caster_pkg::STATE_W-1:0]   bi_pixel,
    input  wire [caster_pkg::FCNT_W-1:0]                            lut_frames,
    input  wire                                                     lut_we,
    input  wire [caster_pkg::LUT_WADDR_W-1:0]                       lut_waddr,
    input  wire [caster_pkg::LUT_DATA_W-1:0]                        lut_wdata,
    scan_if.pipe                                                    scan,
    output logic [caster_pkg::PIX_PER_CLK*caster_pkg::STATE_W-1:0]  bo_pixel,
    output logic                                                    bo_valid,
    output logic [caster_pkg::PIX_PER_CLK*caster_pkg::DRIVE_W-1:0]  epd_sd
);
    import caster_pkg::*;

    logic [PIX_PER_CLK-1:0][GRAY_W-1:0] s1_gray;
    logic [PIX_PER_CLK-1:0][GRAY_W-1:0] s2_gray;
    logic [PIX_PER_CLK-1:0][GRAY_W-1:0] s3_gray;
    logic [PIX_PER_CLK-1:0][GRAY_W-1:0] s4_gray;
    pixel_state_t [PIX_PER_CLK-1:0] s2_state;
    pixel_state_t [PIX_PER_CLK-1:0] s3_state;
    pixel_state_t [PIX_PER_CLK-1:0] s4_state;
    pixel_state_t [PIX_PER_CLK-1:0] upd_state;
    logic [PIX_PER_CLK-1:0][LUT_ADDR_W-1:0] lut_raddr;
    logic [PIX_PER_CLK-1:0][DRIVE_W-1:0] s3_code;
    logic [PIX_PER_CLK-1:0][DRIVE_W-1:0] s4_code;
    logic [PIX_PER_CLK-1:0][DRIVE_W-1:0] upd_drive;
    logic [PIX_PER_CLK-1:0] upd_diff;
    logic s2_active;
    logic s3_active;
    logic s4_active;

    for (genvar i = 0; i < PIX_PER_CLK; i++) begin : g_addr
        logic is_auto;
        logic [FCNT_W-1:0] fcnt;
        logic [GRAY_W-1:0] src;

        // Y8 to Y4, keep the upper nibble
        assign s1_gray[i] = vin_pixel[i*VIN_PIX_W + VIN_PIX_W - GRAY_W +: GRAY_W];

        assign is_auto = (s2_state[i].auto_view.mode == MODE_AUTO);
        assign fcnt = is_auto ? scan.auto_fcnt : s2_state[i].manual_view.fcnt;
        assign src = is_auto ? s2_state[i].auto_view.src : s2_state[i].manual_view.src;
        assign lut_raddr[i] = {lut_frames - fcnt, s2_state[i].manual_view.tgt, src};
    end

    waveform_lut waveform_lut_inst (
        .clk   (clk),
        .we    (lut_we),
        .waddr (lut_waddr),
        .wdata (lut_wdata),
        .raddr (lut_raddr),
        .rdata (s3_code)
    );

    for (genvar i = 0; i < PIX_PER_CLK; i++) begin : g_update
        pixel_update pixel_update_inst (
            .state_in   (s4_state[i]),
            .new_gray   (s4_gray[i]),
            .lut_code   (s4_code[i]),
            .lut_frames (lut_frames),
            .auto_fcnt  (scan.auto_fcnt),
            .drive      (upd_drive[i]),
            .state_out  (upd_state[i]),
            .differs    (upd_diff[i])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_active <= 1'b0;
            s3_active <= 1'b0;
            s4_active <= 1'b0;
            bo_valid <= 1'b0;
            epd_sd <= '0;
            scan.auto_diff <= 1'b0;
        end else begin
            s2_active <= scan.fetch;
            s3_active <= s2_active;
            s4_active <= s3_active;
            bo_valid <= s4_active;
            epd_sd <= s4_active ? upd_drive : '0;
            scan.auto_diff <= s4_active && (|upd_diff);
        end
    end

    always_ff @(posedge clk) begin
        if (scan.fetch) begin
            s2_gray <= s1_gray;
            s2_state <= bi_pixel;
        end
        s3_gray <= s2_gray;
        s3_state <= s2_state;
        s4_gray <= s3_gray;
        s4_state <= s3_state;
        s4_code <= s3_code;
        bo_pixel <= upd_state;
    end

endmodule

`default_nettype wire

/* source/caster.sv */
`timescale 1ns/1ns
`default_nettype none

module caster #(
    parameter int V_FP = 3,
    parameter int V_SYNC = 1,
    parameter int V_BP = 2,
    parameter int V_ACT = 120,
    parameter int H_FP = 2,
    parameter int H_SYNC = 1,
    parameter int H_BP = 2,
    parameter int H_ACT = 40
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                sys_ready,
    input  wire                                vin_vsync,
    input  wire [31:0]                         vin_pixel,
    output logic                               vin_ready,
    output logic                               b_trigger,
    input  wire [63:0]                         bi_pixel,
    output logic                               bi_ready,
    output logic [63:0]                        bo_pixel,
    output logic                               bo_valid,
    input  wire [caster_pkg::FCNT_W-1:0]       lut_frames,
    input  wire                                lut_we,
    input  wire [caster_pkg::LUT_WADDR_W-1:0]  lut_waddr,
    input  wire [caster_pkg::LUT_DATA_W-1:0]   lut_wdata,
    output logic                               epd_gdoe,
    output logic                               epd_gdclk,
    output logic                               epd_gdsp,
    output logic                               epd_sdclk,
    output logic                               epd_sdle,
    output logic                               epd_sdoe,
    output logic [7:0]                         epd_sd,
    output logic                               epd_sdce0
);

    scan_if scan_bus ();

    scan_controller #(
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .V_ACT  (V_ACT),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .H_ACT  (H_ACT)
    ) scan_controller_inst (
        .clk        (clk),
        .rst        (rst),
        .sys_ready  (sys_ready),
        .vin_vsync  (vin_vsync),
        .lut_frames (lut_frames),
        .b_trigger  (b_trigger),
        .epd_gdoe   (epd_gdoe),
        .epd_gdclk  (epd_gdclk),
        .epd_gdsp   (epd_gdsp),
        .epd_sdclk  (epd_sdclk),
        .epd_sdle   (epd_sdle),
        .epd_sdoe   (epd_sdoe),
        .epd_sdce0  (epd_sdce0),
        .fetch_out  (vin_ready),
        .scan       (scan_bus.ctrl)
    );

    pixel_pipe pixel_pipe_inst (
        .clk        (clk),
        .rst        (rst),
        .vin_pixel  (vin_pixel),
        .bi_pixel   (bi_pixel),
        .lut_frames (lut_frames),
        .lut_we     (lut_we),
        .lut_waddr  (lut_waddr),
        .lut_wdata  (lut_wdata),
        .scan       (scan_bus.pipe),
        .bo_pixel   (bo_pixel),
        .bo_valid   (bo_valid),
        .epd_sd     (epd_sd)
    );

    // Both input FIFOs are popped by the same strobe
    assign bi_ready = vin_ready;

endmodule

`default_nettype wire

/* verif/caster_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module caster_checker (
    input wire clk,
    input wire rst,
    input wire vin_ready,
    input wire bo_valid,
    input wire b_trigger,
    input wire epd_gdoe,
    input wire epd_sdce0
);

    // Cycles since reset, so that the delay history is defined
    logic [2:0] settle;

    always_ff @(posedge clk) begin
        if (rst) begin
            settle <= '0;
        end else if (settle != 3'd7) begin
            settle <= settle + 1'b1;
        end
    end

    valid_follows_fetch: assert property (@(posedge clk) disable iff (rst || settle < 3'd5)
        bo_valid == $past(vin_ready, 4))
        else $error("bo_valid does not follow fetch by 4 cycles");

    sdce0_in_gate_window: assert property (@(posedge clk) disable iff (rst)
        !epd_sdce0 |-> epd_gdoe)
        else $error("epd_sdce0 low outside the gate output window");

    trigger_not_in_fetch: assert property (@(posedge clk) disable iff (rst)
        !(b_trigger && vin_ready))
        else $error("b_trigger high during fetch");

endmodule

bind caster caster_checker caster_checker_inst (.*);

`default_nettype wire

/* verif/caster_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module caster_tb;
    import caster_pkg::*;

    localparam int V_ACT = 4;
    localparam int H_ACT = 4;
    localparam int H_TOTAL = 2 + 1 + 2 + H_ACT;
    localparam logic [FCNT_W-1:0] FRAMES = 6'd3;

    logic clk;
    logic rst;
    logic sys_ready;
    logic vin_vsync;
    logic [31:0] vin_pixel;
    logic vin_ready;
    logic b_trigger;
    logic [63:0] bi_pixel;
    logic bi_ready;
    logic [63:0] bo_pixel;
    logic bo_valid;
    logic [FCNT_W-1:0] lut_frames;
    logic lut_we;
    logic [LUT_WADDR_W-1:0] lut_waddr;
    logic [LUT_DATA_W-1:0] lut_wdata;
    logic epd_gdoe;
    logic epd_gdclk;
    logic epd_gdsp;
    logic epd_sdclk;
    logic epd_sdle;
    logic epd_sdoe;
    logic [7:0] epd_sd;
    logic epd_sdce0;

    logic [31:0] lfsr;
    logic [DRIVE_W-1:0] lut_model [2**LUT_ADDR_W];
    logic [63:0] in_words [$];
    logic [31:0] in_pix [$];
    logic [63:0] exp_words [$];
    logic [7:0] exp_sd [$];
    logic [FCNT_W-1:0] auto_cnt;
    logic auto_flag;

    caster #(.V_ACT(V_ACT), .H_ACT(H_ACT)) caster_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_state(input string name, input pixel_state_t exp,
                               input pixel_state_t act);
        if (act !== exp) fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_drive(input string name, input logic [DRIVE_W-1:0] exp,
                               input logic [DRIVE_W-1:0] act);
        if (act !== exp) fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) fail_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
    endtask

    // Update rule for one pixel using the table address of the old word
    task automatic model_pixel(input pixel_state_t st, input logic [GRAY_W-1:0] gray,
                               output pixel_state_t nxt, output logic [DRIVE_W-1:0] drv,
                               output logic diff);
        logic [FCNT_W-1:0] fc;
        logic [DRIVE_W-1:0] code;
        nxt = st;
        drv = '0;
        diff = 1'b0;
        fc = st[15] ? auto_cnt : st.manual_view.fcnt;
        code = lut_model[{FRAMES - fc, st[3:0], st[15] ? st[7:4] : st[13:10]}];
        if (!st[15]) begin
            if (fc != 0) begin
                drv = code;
                nxt.manual_view.fcnt = fc - 1'b1;
                if (fc == 1) nxt.manual_view.src = st.manual_view.tgt;
            end else if (gray != st.manual_view.src) begin
                nxt.manual_view.tgt = gray;
                nxt.manual_view.fcnt = FRAMES;
            end
        end else begin
            if (auto_cnt != 0) drv = code;
            if (auto_cnt == 1) nxt.auto_view.src = st.auto_view.tgt;
            if (auto_cnt == 0) begin
                diff = (gray != st.auto_view.tgt);
                nxt.auto_view.tgt = gray;
            end
        end
    endtask

    // Feed one frame of queued groups and compare every output group
    task automatic run_frame(input string name);
        pixel_state_t nxt;
        logic [DRIVE_W-1:0] drv;
        logic diff;
        logic any_diff;
        logic [63:0] w;
        logic [7:0] sd;
        logic seen_gdoe;
        logic done;
        int n_fetch;
        int n_bi;
        int n_valid;
        int n_gdsp;
        int n_trig;
        if (auto_cnt == 0 && auto_flag) auto_cnt = FRAMES;
        else if (auto_cnt != 0) auto_cnt = auto_cnt - 1'b1;
        auto_flag = 1'b0;
        any_diff = 1'b0;
        for (int g = 0; g < in_words.size(); g++) begin
            for (int p = 0; p < 4; p++) begin
                model_pixel(in_words[g][p*16 +: 16], in_pix[g][p*8+4 +: 4], nxt, drv, diff);
                w[p*16 +: 16] = nxt;
                sd[p*2 +: 2] = drv;
                any_diff = any_diff | diff;
            end
            exp_words.push_back(w);
            exp_sd.push_back(sd);
        end
        n_fetch = 0;
        n_bi = 0;
        n_valid = 0;
        n_gdsp = 0;
        n_trig = 0;
        seen_gdoe = 1'b0;
        done = 1'b0;
        for (int cyc = 0; cyc < 400 && !done; cyc++) begin
            @(posedge clk);
            #2;
            vin_vsync = (cyc == 0);
            if (vin_ready) begin
                if (in_words.size() == 0) fail_run("DUT fetched more pixel groups than a frame has");
                bi_pixel = in_words.pop_front();
                vin_pixel = in_pix.pop_front();
            end
            @(negedge clk);
            n_fetch += vin_ready;
            n_bi += bi_ready;
            n_gdsp += !epd_gdsp;
            n_trig += b_trigger;
            if (bo_valid) begin
                n_valid++;
                if (exp_words.size() == 0) fail_run("bo_valid high with no group expected");
                w = exp_words.pop_front();
                sd = exp_sd.pop_front();
                for (int p = 0; p < 4; p++) begin
                    check_state(name, w[p*16 +: 16], bo_pixel[p*16 +: 16]);
                    check_drive(name, sd[p*2 +: 2], epd_sd[p*2 +: 2]);
                end
            end else begin
                for (int p = 0; p < 4; p++) begin
                    check_drive({name, " idle sd"}, 2'b00, epd_sd[p*2 +: 2]);
                end
            end
            if (epd_gdoe) seen_gdoe = 1'b1;
            done = seen_gdoe && !epd_gdoe;
        end
        if (!done) fail_run("Timeout waiting for the frame to finish");
        check_count({name, " fetch cycles"}, V_ACT * H_ACT, n_fetch);
        check_count({name, " bi_ready cycles"}, V_ACT * H_ACT, n_bi);
        check_count({name, " bo_valid cycles"}, V_ACT * H_ACT, n_valid);
        check_count({name, " gdsp low cycles"}, H_TOTAL, n_gdsp);
        check_count({name, " b_trigger cycles"}, VS_DELAY + 1, n_trig);
        auto_flag = any_diff;
    endtask

    task automatic test_reset_values();
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_bit("reset vin_ready", 1'b0, vin_ready);
            check_bit("reset bi_ready", 1'b0, bi_ready);
            check_bit("reset b_trigger", 1'b0, b_trigger);
            check_bit("reset bo_valid", 1'b0, bo_valid);
            check_bit("reset gdoe", 1'b0, epd_gdoe);
            check_bit("reset sdoe", 1'b0, epd_sdoe);
            check_bit("reset sdle", 1'b0, epd_sdle);
            check_bit("reset gdclk", 1'b0, epd_gdclk);
            check_bit("reset sdclk", 1'b0, epd_sdclk);
            check_bit("reset gdsp", 1'b1, epd_gdsp);
            check_bit("reset sdce0", 1'b1, epd_sdce0);
            for (int p = 0; p < 4; p++) begin
                check_drive("reset sd", 2'b00, epd_sd[p*2 +: 2]);
            end
        end
    endtask

    task automatic load_lut();
        for (int a = 0; a < 2**LUT_WADDR_W; a++) begin
            @(posedge clk);
            #2;
            lut_we = 1'b1;
            lut_waddr = a;
            lut_wdata = rand_bits(8);
            for (int k = 0; k < 4; k++) lut_model[a*4 + k] = lut_wdata[k*2 +: 2];
        end
        @(posedge clk);
        #2;
        lut_we = 1'b0;
    endtask

    // Kind 0 is manual running, 1 manual idle and 2 auto with one change in diff_group
    task automatic fill_frame(input int kind, input int diff_group);
        pixel_state_t st;
        logic [63:0] w;
        logic [31:0] pix;
        logic [GRAY_W-1:0] gray;
        for (int g = 0; g < V_ACT * H_ACT; g++) begin
            for (int p = 0; p < 4; p++) begin
                st = rand_bits(16);
                gray = rand_bits(4);
                if (kind == 2) begin
                    st.auto_view.mode = 1'b1;
                    gray = (g == diff_group && p == 2) ? st[3:0] + 1'b1 : st[3:0];
                end else begin
                    st.manual_view.mode = 1'b0;
                    st.manual_view.fcnt = (kind == 0) ? rand_bits(2) % 3 + 1 : 0;
                    if (kind == 1 && rand_bits(1)) gray = st.manual_view.src;
                end
                w[p*16 +: 16] = st;
                pix[p*8 +: 8] = {gray, 4'(rand_bits(4))};
            end
            in_words.push_back(w);
            in_pix.push_back(pix);
        end
    endtask

    initial begin
        lfsr = 32'h2694842a;
        rst = 1'b1;
        sys_ready = 1'b0;
        vin_vsync = 1'b0;
        vin_pixel = '0;
        bi_pixel = '0;
        lut_frames = FRAMES;
        lut_we = 1'b0;
        lut_waddr = '0;
        lut_wdata = '0;
        auto_cnt = '0;
        auto_flag = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        sys_ready = 1'b1;
        test_reset_values();
        load_lut();
        fill_frame(0, -1);
        run_frame("manual_running");
        fill_frame(1, -1);
        run_frame("manual_idle");
        fill_frame(2, 5);
        run_frame("auto_change");
        for (int f = 0; f < 4; f++) begin
            fill_frame(2, -1);
            run_frame($sformatf("auto_count_%0d", f));
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* caster.f */
common/caster_pkg.sv
common/scan_if.sv
source/scan_controller.sv
pixel_pipe/waveform_lut.sv
pixel_pipe/pixel_update.sv
pixel_pipe/pixel_pipe.sv
source/caster.sv
verif/caster_checker.sv
verif/caster_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the caster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f caster.f --top-module caster_tb -o caster_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/caster_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation returned status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Test OK$"; then
    exit 0
fi
exit 1
